// File: sources.f
rtl/BasicTypes.sv
rtl/PipeTypes.sv
rtl/IntRegFile.sv
rtl/CycleCounter.sv
rtl/CsrFile.sv
rtl/PipelineController.sv
rtl/RegReadStage.sv
rtl/RegReadTop.sv
sim/regRead_checker.sv
sim/RegReadTb.sv

// File: sim/RegReadTb.sv
// Testbench for the register-read slice: random stimulus, reference model and output compare.
`timescale 1ns/1ns

module RegReadTb
    import BasicTypes::*;
    import PipeTypes::*;
();

    localparam int resetCycles = 5;
    localparam int stimCycles = 1500;
    localparam int timeoutLimit = stimCycles + 500;  // reset plus margin.

    logic clk;
    logic rstN;
    DecodePacket decodeIn;
    WritebackPort wb;
    logic downstreamStall;
    RegReadPacket rrOut;
    logic rrStall;
    logic trapRedirect;

    // reference model state.
    DataPath modelRegs [regNum];
    DataPath modelMscratch;
    DataPath modelCycle;
    DataPath modelInstret;
    CtrlState modelState;
    RegReadPacket expOut;
    logic modelStalled;  // stage held at the last edge.

    integer seed;
    int stallBurst;
    int runCycles;
    int comparedCycles;
    int errorCount;
    logic compareOn;

    RegReadTop u_RegReadTop (
        .clk(clk),
        .rstN(rstN),
        .decodeIn(decodeIn),
        .wb(wb),
        .downstreamStall(downstreamStall),
        .rrOut(rrOut),
        .rrStall(rrStall),
        .trapRedirect(trapRedirect)
    );

    always #50 clk = ~clk;

    function automatic int unsigned pick(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // low registers most of the time so reads hit recent writes.
    function automatic RegAddrPath randomRegAddr();
        if (pick(4) != 0) begin
            return RegAddrPath'(pick(8));
        end
        return RegAddrPath'(pick(32));
    endfunction

    function automatic CsrAddrPath randomCsrAddr();
        case (pick(7))
            0: return csrMisa;
            1: return csrMscratch;
            2: return csrMcycle;
            3: return csrMinstret;
            4: return 12'h300;  // mstatus, not implemented here.
            5: return 12'h7C0;
            default: return 12'hB01;
        endcase
    endfunction

    function automatic DecodePacket randomPacket();
        DecodePacket d;
        d = '0;
        d.valid = (pick(8) != 0);
        d.op.csrReadEnable = (pick(2) == 1);
        d.op.regWriteEnable = (pick(2) == 1);
        d.op.isSystem = (pick(2) == 1);
        d.pc = $random(seed) & 32'hFFFF_FFFC;
        d.insn = $random(seed);
        d.csrAddr = randomCsrAddr();
        d.srcRegAddr1 = randomRegAddr();
        d.srcRegAddr2 = randomRegAddr();
        d.dstRegAddr = randomRegAddr();
        if (pick(16) == 0) begin  // rare trap from decode.
            d.trapInfo.valid = 1'b1;
            d.trapInfo.cause = ExceptionCode_Breakpoint;
            d.trapInfo.value = d.pc;
        end
        return d;
    endfunction

    // expected stage output for a packet loaded at this edge.
    function automatic RegReadPacket predictPacket(DecodePacket d);
        RegReadPacket p;
        logic illegal;
        p = '0;
        illegal = 1'b0;
        p.valid = d.valid;
        p.op = d.op;
        p.pc = d.pc;
        p.insn = d.insn;
        p.csrAddr = d.csrAddr;
        p.srcRegAddr1 = d.srcRegAddr1;
        p.srcRegAddr2 = d.srcRegAddr2;
        p.dstRegAddr = d.dstRegAddr;
        p.srcIntRegValue1 = (d.srcRegAddr1 == 0) ? '0 : modelRegs[d.srcRegAddr1];
        p.srcIntRegValue2 = (d.srcRegAddr2 == 0) ? '0 : modelRegs[d.srcRegAddr2];
        if (d.op.csrReadEnable) begin
            case (d.csrAddr)
                csrMisa: p.srcCsrValue = misaValue;
                csrMscratch: p.srcCsrValue = modelMscratch;
                csrMcycle: p.srcCsrValue = modelCycle;
                csrMinstret: p.srcCsrValue = modelInstret;
                default: illegal = 1'b1;
            endcase
        end
        p.trapInfo = d.trapInfo;
        if (!d.trapInfo.valid && illegal) begin
            p.trapInfo.valid = 1'b1;
            p.trapInfo.cause = ExceptionCode_IllegalInsn;
            p.trapInfo.value = d.insn;
        end
        return p;
    endfunction

    // advance the model by one edge, using the inputs seen at that edge.
    task automatic stepModel();
        logic flushNow;
        logic stallNow;
        logic retireNow;
        CtrlState nextState;
        if (!rstN) begin
            for (int i = 0; i < regNum; i++) begin
                modelRegs[i] = '0;
            end
            modelMscratch = '0;
            modelCycle = '0;
            modelInstret = '0;
            modelState = CtrlRun;
            expOut = '0;
            modelStalled = 1'b0;
        end
        else begin
            flushNow = (modelState == CtrlRedirect);
            stallNow = downstreamStall && !flushNow;
            retireNow = expOut.valid && !stallNow;
            if (flushNow) begin
                nextState = downstreamStall ? CtrlHold : CtrlRun;
            end
            else if (expOut.valid && expOut.trapInfo.valid && !downstreamStall) begin
                nextState = CtrlRedirect;  // trap accepted downstream.
            end
            else begin
                nextState = downstreamStall ? CtrlHold : CtrlRun;
            end
            if (flushNow) begin
                expOut = '0;
            end
            else if (!stallNow) begin
                expOut = predictPacket(decodeIn);
            end
            // writeback lands after the read, no bypass.
            if (wb.enable && wb.isCsr && wb.csrAddr == csrMscratch) begin
                modelMscratch = wb.data;
            end
            else if (wb.enable && !wb.isCsr && wb.regAddr != 0) begin
                modelRegs[wb.regAddr] = wb.data;
            end
            modelCycle = modelCycle + 1;
            if (retireNow) begin
                modelInstret = modelInstret + 1;
            end
            modelState = nextState;
            modelStalled = stallNow;
        end
    endtask

    task automatic driveInputs();
        WritebackPort w;
        w = '0;
        if (!modelStalled) begin
            decodeIn <= randomPacket();  // held while stalled.
        end
        if (pick(2) == 1) begin
            w.enable = 1'b1;
            w.isCsr = (pick(4) == 0);
            w.regAddr = randomRegAddr();
            w.csrAddr = (pick(2) == 0) ? csrMscratch : randomCsrAddr();
            w.data = $random(seed);
        end
        wb <= w;
        if (stallBurst > 0) begin
            downstreamStall <= 1'b1;
            stallBurst--;
        end
        else if (pick(10) == 0) begin
            downstreamStall <= 1'b1;
            stallBurst = pick(4);
        end
        else begin
            downstreamStall <= 1'b0;
        end
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        errorCount++;
        $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    always @(negedge clk) begin : compareOutputs
        logic expStall;
        logic expRedirect;
        expStall = downstreamStall && (modelState != CtrlRedirect);
        expRedirect = (modelState == CtrlRedirect);
        if (compareOn) begin
            comparedCycles++;
            if (rrOut.valid !== expOut.valid)
                reportMismatch("rrOut.valid", expOut.valid, rrOut.valid);
            if (rrOut.op !== expOut.op)
                reportMismatch("rrOut.op", expOut.op, rrOut.op);
            if (rrOut.pc !== expOut.pc)
                reportMismatch("rrOut.pc", expOut.pc, rrOut.pc);
            if (rrOut.insn !== expOut.insn)
                reportMismatch("rrOut.insn", expOut.insn, rrOut.insn);
            if (rrOut.csrAddr !== expOut.csrAddr)
                reportMismatch("rrOut.csrAddr", expOut.csrAddr, rrOut.csrAddr);
            if (rrOut.srcRegAddr1 !== expOut.srcRegAddr1)
                reportMismatch("rrOut.srcRegAddr1", expOut.srcRegAddr1, rrOut.srcRegAddr1);
            if (rrOut.srcRegAddr2 !== expOut.srcRegAddr2)
                reportMismatch("rrOut.srcRegAddr2", expOut.srcRegAddr2, rrOut.srcRegAddr2);
            if (rrOut.dstRegAddr !== expOut.dstRegAddr)
                reportMismatch("rrOut.dstRegAddr", expOut.dstRegAddr, rrOut.dstRegAddr);
            if (rrOut.trapInfo !== expOut.trapInfo)
                reportMismatch("rrOut.trapInfo", expOut.trapInfo, rrOut.trapInfo);
            if (rrOut.srcCsrValue !== expOut.srcCsrValue)
                reportMismatch("rrOut.srcCsrValue", expOut.srcCsrValue, rrOut.srcCsrValue);
            if (rrOut.srcIntRegValue1 !== expOut.srcIntRegValue1)
                reportMismatch("rrOut.srcIntRegValue1", expOut.srcIntRegValue1,
                               rrOut.srcIntRegValue1);
            if (rrOut.srcIntRegValue2 !== expOut.srcIntRegValue2)
                reportMismatch("rrOut.srcIntRegValue2", expOut.srcIntRegValue2,
                               rrOut.srcIntRegValue2);
            if (rrStall !== expStall)
                reportMismatch("rrStall", expStall, rrStall);
            if (trapRedirect !== expRedirect)
                reportMismatch("trapRedirect", expRedirect, trapRedirect);
        end
    end

    always @(posedge clk) begin
        runCycles++;
        if (runCycles > timeoutLimit) begin
            $display("timeout after %0d cycles, the stimulus never completed", timeoutLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        decodeIn = '0;
        wb = '0;
        downstreamStall = 1'b0;
        seed = 32'heccd;
        stallBurst = 0;
        runCycles = 0;
        comparedCycles = 0;
        errorCount = 0;
        compareOn = 1'b0;
        repeat (resetCycles) begin
            @(posedge clk);
            stepModel();
            compareOn = 1'b1;
        end
        rstN <= 1'b1;
        for (int i = 0; i < stimCycles; i++) begin
            @(posedge clk);
            stepModel();
            driveInputs();
        end
        @(negedge clk);
        @(posedge clk);
        $display("compared %0d cycles, %0d mismatches", comparedCycles, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim/regRead_checker.sv
// Assertion checker for the register-read stage register and the pipeline controller.
`timescale 1ns/1ns

module RegReadChecker
    import PipeTypes::*;
(
    input logic clk,
    input logic rstN,
    input logic flush,
    input logic stall,
    input RegReadPacket rrOut,
    input logic trapRedirect
);

    // flush empties the stage at the same edge.
    flushClearsValid: assert property (@(posedge clk) disable iff (!rstN)
        flush |=> !rrOut.valid)
        else $error("rrOut.valid still set after a flush");

    stallHoldsOutput: assert property (@(posedge clk) disable iff (!rstN)
        stall && !flush |=> $stable(rrOut))
        else $error("rrOut changed during a stall");

    redirectOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        trapRedirect |=> !trapRedirect)
        else $error("trapRedirect high for more than one cycle");

    validLowAfterReset: assert property (@(posedge clk)
        !rstN |=> !rrOut.valid)
        else $error("rrOut.valid set right after reset");

endmodule

// watches the stage register and the controller outputs.
bind RegReadTop RegReadChecker u_checker (
    .clk(clk),
    .rstN(rstN),
    .flush(flush),
    .stall(rrStall),
    .rrOut(rrOut),
    .trapRedirect(trapRedirect)
);

// File: rtl/RegReadTop.sv
// Register-read slice top: stage, integer registers, CSR file, counters and controller.
`timescale 1ns/1ns

module RegReadTop
    import BasicTypes::*;
    import PipeTypes::*;
(
    input  logic clk,
    input  logic rstN,
    input  DecodePacket decodeIn,
    input  WritebackPort wb,
    input  logic downstreamStall,
    output RegReadPacket rrOut,
    output logic rrStall,
    output logic trapRedirect
);

    RegAddrPath readAddr1;
    RegAddrPath readAddr2;
    DataPath readValue1;
    DataPath readValue2;
    CsrAddrPath csrReadAddr;
    logic csrReadEnable;
    DataPath csrReadValue;
    logic csrReadIllegal;
    DataPath cycleCount;
    DataPath instretCount;
    logic flush;
    logic trapAtOutput;
    logic regWriteEnable;
    logic retire;

    assign trapAtOutput = rrOut.valid && rrOut.trapInfo.valid;
    assign regWriteEnable = wb.enable && !wb.isCsr;
    assign retire = rrOut.valid && !rrStall;  // packet accepted downstream.

    RegReadStage u_stage (
        .clk(clk),
        .rstN(rstN),
        .decodeIn(decodeIn),
        .flush(flush),
        .stall(rrStall),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readValue1(readValue1),
        .readValue2(readValue2),
        .csrReadAddr(csrReadAddr),
        .csrReadEnable(csrReadEnable),
        .csrReadValue(csrReadValue),
        .csrReadIllegal(csrReadIllegal),
        .rrOut(rrOut)
    );

    IntRegFile u_regFile (
        .clk(clk),
        .rstN(rstN),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2),
        .readValue1(readValue1),
        .readValue2(readValue2),
        .writeEnable(regWriteEnable),
        .writeAddr(wb.regAddr),
        .writeData(wb.data)
    );

    CsrFile u_csr (
        .clk(clk),
        .rstN(rstN),
        .readEnable(csrReadEnable),
        .readAddr(csrReadAddr),
        .readValue(csrReadValue),
        .readIllegal(csrReadIllegal),
        .wb(wb),
        .cycleCount(cycleCount),
        .instretCount(instretCount)
    );

    CycleCounter u_counter (
        .clk(clk),
        .rstN(rstN),
        .retire(retire),
        .cycleCount(cycleCount),
        .instretCount(instretCount)
    );

    PipelineController u_ctrl (
        .clk(clk),
        .rstN(rstN),
        .downstreamStall(downstreamStall),
        .trapAtOutput(trapAtOutput),
        .rrStall(rrStall),
        .flush(flush),
        .trapRedirect(trapRedirect)
    );

endmodule

// File: rtl/RegReadStage.sv
// Register-read stage: drives operand reads and registers the packet, inserting CSR traps.
`timescale 1ns/1ns

module RegReadStage
    import BasicTypes::*;
    import PipeTypes::*;
(
    input  logic clk,
    input  logic rstN,
    input  DecodePacket decodeIn,
    input  logic flush,
    input  logic stall,
    output RegAddrPath readAddr1,
    output RegAddrPath readAddr2,
    input  DataPath readValue1,
    input  DataPath readValue2,
    output CsrAddrPath csrReadAddr,
    output logic csrReadEnable,
    input  DataPath csrReadValue,
    input  logic csrReadIllegal,
    output RegReadPacket rrOut
);

    // read addresses come straight from the incoming packet.
    always_comb begin
        readAddr1 = decodeIn.srcRegAddr1;
        readAddr2 = decodeIn.srcRegAddr2;
        csrReadAddr = decodeIn.csrAddr;
        csrReadEnable = decodeIn.op.csrReadEnable;
    end

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            rrOut <= '0;
        end
        else if (stall) begin
            rrOut <= rrOut;  // hold everything.
        end
        else begin
            rrOut.valid <= decodeIn.valid;
            rrOut.op <= decodeIn.op;
            rrOut.pc <= decodeIn.pc;
            rrOut.insn <= decodeIn.insn;
            rrOut.csrAddr <= decodeIn.csrAddr;
            rrOut.srcRegAddr1 <= decodeIn.srcRegAddr1;
            rrOut.srcRegAddr2 <= decodeIn.srcRegAddr2;
            rrOut.dstRegAddr <= decodeIn.dstRegAddr;
            rrOut.srcCsrValue <= csrReadValue;
            rrOut.srcIntRegValue1 <= readValue1;
            rrOut.srcIntRegValue2 <= readValue2;

            // an earlier trap keeps priority over the CSR check.
            if (!decodeIn.trapInfo.valid && csrReadIllegal) begin
                rrOut.trapInfo.valid <= 1'b1;
                rrOut.trapInfo.cause <= ExceptionCode_IllegalInsn;
                rrOut.trapInfo.value <= decodeIn.insn;
            end
            else begin
                rrOut.trapInfo <= decodeIn.trapInfo;
            end
        end
    end

endmodule

// File: rtl/PipelineController.sv
// Pipeline controller FSM producing the stall and flush levels of the stage.
`timescale 1ns/1ns

module PipelineController
    import PipeTypes::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic downstreamStall,
    input  logic trapAtOutput,
    output logic rrStall,
    output logic flush,
    output logic trapRedirect
);

    CtrlState state;
    CtrlState nextState;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= CtrlRun;
        end
        else begin
            state <= nextState;
        end
    end

    // a trap is taken once downstream accepts it.
    always_comb begin
        nextState = state;
        case (state)
            CtrlRun, CtrlHold: begin
                if (trapAtOutput && !downstreamStall) begin
                    nextState = CtrlRedirect;
                end
                else if (downstreamStall) begin
                    nextState = CtrlHold;
                end
                else begin
                    nextState = CtrlRun;
                end
            end
            CtrlRedirect: begin
                nextState = downstreamStall ? CtrlHold : CtrlRun;  // one cycle only.
            end
            default: begin
                nextState = CtrlRun;
            end
        endcase
    end

    assign flush = (state == CtrlRedirect);
    assign trapRedirect = (state == CtrlRedirect);
    assign rrStall = downstreamStall && (state != CtrlRedirect);  // flush wins.

endmodule

// File: rtl/CsrFile.sv
// CSR file: read decode with illegal-address flag, and the mscratch register.
`timescale 1ns/1ns

module CsrFile
    import BasicTypes::*;
    import PipeTypes::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic readEnable,
    input  CsrAddrPath readAddr,
    output DataPath readValue,
    output logic readIllegal,
    input  WritebackPort wb,
    input  DataPath cycleCount,
    input  DataPath instretCount
);

    DataPath mscratch;
    logic mscratchWrite;

    // only mscratch is writable, other CSR writes are dropped.
    assign mscratchWrite = wb.enable && wb.isCsr && (wb.csrAddr == csrMscratch);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mscratch <= '0;
        end
        else if (mscratchWrite) begin
            mscratch <= wb.data;
        end
    end

    // read mux.
    always_comb begin
        readValue = '0;
        readIllegal = 1'b0;
        if (readEnable) begin
            case (readAddr)
                csrMisa: begin
                    readValue = misaValue;
                end
                csrMscratch: begin
                    readValue = mscratch;  // old value on a same-cycle write.
                end
                csrMcycle: begin
                    readValue = cycleCount;
                end
                csrMinstret: begin
                    readValue = instretCount;
                end
                default: begin
                    readIllegal = 1'b1;  // unimplemented address.
                end
            endcase
        end
    end

endmodule

// File: rtl/CycleCounter.sv
// Cycle counter block providing mcycle and minstret.
`timescale 1ns/1ns

module CycleCounter
    import BasicTypes::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic retire,
    output DataPath cycleCount,
    output DataPath instretCount
);

    // both counters simply wrap.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cycleCount <= '0;
            instretCount <= '0;
        end
        else begin
            cycleCount <= cycleCount + 1'b1;
            if (retire) begin
                instretCount <= instretCount + 1'b1;  // one per accepted packet.
            end
        end
    end

endmodule

// File: rtl/IntRegFile.sv
// Integer register file with two combinational read ports and one write port.
`timescale 1ns/1ns

module IntRegFile
    import BasicTypes::*;
(
    input  logic clk,
    input  logic rstN,
    input  RegAddrPath readAddr1,
    input  RegAddrPath readAddr2,
    output DataPath readValue1,
    output DataPath readValue2,
    input  logic writeEnable,
    input  RegAddrPath writeAddr,
    input  DataPath writeData
);

    DataPath regs [regNum];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regNum; i++) begin
                regs[i] <= '0;
            end
        end
        else if (writeEnable && writeAddr != '0) begin  // x0 is hardwired.
            regs[writeAddr] <= writeData;
        end
    end

    // no bypass, so a same-cycle write shows up one cycle later.
    always_comb begin
        readValue1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
        readValue2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
    end

endmodule

// File: rtl/PipeTypes.sv
// Pipeline types: op info, trap info, stage packets, writeback port and controller states.
package PipeTypes;

    import BasicTypes::*;

    // op bits the register-read stage cares about.
    typedef struct packed {
        logic csrReadEnable;   // insn reads a CSR.
        logic regWriteEnable;  // insn writes dstRegAddr.
        logic isSystem;
    } OpInfo;

    typedef struct packed {
        logic valid;
        ExceptionCode cause;
        DataPath value;  // faulting insn word.
    } TrapInfo;

    // packet from decode.
    typedef struct packed {
        logic valid;
        OpInfo op;
        DataPath pc;
        DataPath insn;
        CsrAddrPath csrAddr;
        RegAddrPath srcRegAddr1;
        RegAddrPath srcRegAddr2;
        RegAddrPath dstRegAddr;
        TrapInfo trapInfo;
    } DecodePacket;

    // decode packet plus the source operands read in this stage.
    typedef struct packed {
        logic valid;
        OpInfo op;
        DataPath pc;
        DataPath insn;
        CsrAddrPath csrAddr;
        RegAddrPath srcRegAddr1;
        RegAddrPath srcRegAddr2;
        RegAddrPath dstRegAddr;
        TrapInfo trapInfo;
        DataPath srcCsrValue;
        DataPath srcIntRegValue1;
        DataPath srcIntRegValue2;
    } RegReadPacket;

    // writeback into the int regs or the CSR file.
    typedef struct packed {
        logic enable;
        logic isCsr;  // selects the CSR file.
        RegAddrPath regAddr;
        CsrAddrPath csrAddr;
        DataPath data;
    } WritebackPort;

    typedef enum logic [1:0] {
        CtrlRun,
        CtrlHold,      // downstream stalled.
        CtrlRedirect   // flushing after a trap.
    } CtrlState;

endpackage

// File: rtl/BasicTypes.sv
// Basic machine types: data and address widths, CSR map and exception codes.
package BasicTypes;

    // machine widths.
    localparam int xlen = 32;
    localparam int regAddrWidth = 5;
    localparam int csrAddrWidth = 12;
    localparam int exceptionCodeWidth = 4;

    localparam int regNum = 1 << regAddrWidth;  // integer registers.

    typedef logic [xlen-1:0] DataPath;
    typedef logic [regAddrWidth-1:0] RegAddrPath;
    typedef logic [csrAddrWidth-1:0] CsrAddrPath;

    // implemented CSR addresses.
    localparam CsrAddrPath csrMisa = 12'h301;      // read only.
    localparam CsrAddrPath csrMscratch = 12'h340;  // read/write.
    localparam CsrAddrPath csrMcycle = 12'hB00;    // read only.
    localparam CsrAddrPath csrMinstret = 12'hB02;  // read only.

    // MXL = 1 for RV32, extension bit I set.
    localparam DataPath misaValue = 32'h4000_0100;

    // trap causes, numbered as in the privileged spec.
    typedef enum logic [exceptionCodeWidth-1:0] {
        ExceptionCode_None = 4'h0,
        ExceptionCode_IllegalInsn = 4'h2,
        ExceptionCode_Breakpoint = 4'h3
    } ExceptionCode;

endpackage
